//--- source/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } fetch_entry_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      reg_we;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      illegal;
    } decode_entry_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_we;
        logic      illegal;
        word_t     result;
    } exec_entry_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } bypass_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_we;
        word_t     data;
        logic      illegal;
    } commit_t;

endpackage

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  core_pkg::word_t        imem_rdata_i,
    input  logic                   imem_valid_i,
    input  core_pkg::redirect_t    redirect_i,
    output core_pkg::word_t        imem_addr_o,
    output core_pkg::fetch_entry_t fetch_o
);
    import core_pkg::*;

    word_t        pc_q;
    word_t        pc_d;
    fetch_entry_t fetch_d;
    fetch_entry_t fetch_q;

    // a redirect wins over sequential fetch
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.pc;
        end else if (imem_valid_i) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    // bubble when memory is not ready or the word is on a dead path
    assign fetch_d.valid = imem_valid_i && !redirect_i.valid;
    assign fetch_d.pc    = pc_q;
    assign fetch_d.instr = imem_rdata_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q    <= RESET_PC;
            fetch_q <= '0;
        end else begin
            pc_q    <= pc_d;
            fetch_q <= fetch_d;
        end
    end

    assign imem_addr_o = pc_q;
    assign fetch_o     = fetch_q;

    // targets come from execute offsets, so alignment is checked here
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        imem_addr_o[1:0] == 2'b00);

endmodule

//--- source/decoder.sv
module decoder (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  core_pkg::fetch_entry_t  fetch_i,
    input  logic                    flush_i,
    input  core_pkg::word_t         rs1_data_i,
    input  core_pkg::word_t         rs2_data_i,
    output core_pkg::reg_addr_t     rs1_addr_o,
    output core_pkg::reg_addr_t     rs2_addr_o,
    output core_pkg::decode_entry_t decode_o
);
    import core_pkg::*;

    instr_u        instr;
    logic          illegal;
    logic          funct7_ok;
    decode_entry_t decode_d;
    decode_entry_t decode_q;

    assign instr      = fetch_i.instr;
    assign rs1_addr_o = instr.r.rs1;
    assign rs2_addr_o = instr.r.rs2;

    // only SUB uses the alternate funct7
    assign funct7_ok = (instr.r.funct7 == 7'b0000000) ||
                       (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000);

    always_comb begin
        decode_d          = '0;
        illegal           = 1'b0;
        decode_d.valid    = fetch_i.valid && !flush_i;
        decode_d.pc       = fetch_i.pc;
        decode_d.rs1      = instr.r.rs1;
        decode_d.rs2      = instr.r.rs2;
        decode_d.rs1_data = rs1_data_i;
        decode_d.rs2_data = rs2_data_i;
        decode_d.rd       = instr.r.rd;
        decode_d.alu_op   = ALU_ADD;

        case (instr.r.opcode)
            OPC_OP: begin
                decode_d.reg_we = 1'b1;
                illegal         = !funct7_ok;
                case (instr.r.funct3)
                    3'b000: decode_d.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: decode_d.alu_op = ALU_SLL;
                    3'b010: decode_d.alu_op = ALU_SLT;
                    3'b100: decode_d.alu_op = ALU_XOR;
                    3'b101: decode_d.alu_op = ALU_SRL;
                    3'b110: decode_d.alu_op = ALU_OR;
                    3'b111: decode_d.alu_op = ALU_AND;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                decode_d.reg_we  = 1'b1;
                decode_d.use_imm = 1'b1;
                decode_d.imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                case (instr.i.funct3)
                    3'b000: decode_d.alu_op = ALU_ADD;
                    3'b010: decode_d.alu_op = ALU_SLT;
                    3'b100: decode_d.alu_op = ALU_XOR;
                    3'b110: decode_d.alu_op = ALU_OR;
                    3'b111: decode_d.alu_op = ALU_AND;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                decode_d.reg_we  = 1'b1;
                decode_d.use_imm = 1'b1;
                decode_d.alu_op  = ALU_PASS_B;
                decode_d.imm     = {instr.u.imm20, 12'b0};
            end
            OPC_BRANCH: begin
                decode_d.is_branch = 1'b1;
                decode_d.branch_ne = instr.b.funct3[0];
                decode_d.imm       = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                                      instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                illegal            = instr.b.funct3[2:1] != 2'b00;
            end
            OPC_JAL: begin
                decode_d.reg_we = 1'b1;
                decode_d.is_jal = 1'b1;
                decode_d.imm    = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                                   instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: illegal = 1'b1;
        endcase

        // an unknown word retires without side effects
        decode_d.illegal = illegal;
        if (illegal) begin
            decode_d.reg_we    = 1'b0;
            decode_d.is_branch = 1'b0;
            decode_d.is_jal    = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            decode_q <= '0;
        end else begin
            decode_q <= decode_d;
        end
    end

    assign decode_o = decode_q;

    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(decode_o.illegal && decode_o.reg_we));

endmodule

//--- source/regfile.sv
module regfile (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o
);
    import core_pkg::*;

    // x0 has no storage
    word_t regs_q [1:31];

    // same-cycle write is visible on the read port
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

//--- source/alu_exec.sv
module alu_exec (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  core_pkg::decode_entry_t decode_i,
    input  core_pkg::bypass_t       bypass_i,
    output core_pkg::redirect_t     redirect_o,
    output core_pkg::exec_entry_t   exec_o
);
    import core_pkg::*;

    word_t       op_a;
    word_t       op_b_reg;
    word_t       op_b;
    word_t       alu_res;
    logic        taken;
    exec_entry_t exec_d;
    exec_entry_t exec_q;

    // writeback result overrides the value read in decode
    always_comb begin
        op_a     = decode_i.rs1_data;
        op_b_reg = decode_i.rs2_data;
        if (bypass_i.valid && bypass_i.rd != '0 && bypass_i.rd == decode_i.rs1) begin
            op_a = bypass_i.data;
        end
        if (bypass_i.valid && bypass_i.rd != '0 && bypass_i.rd == decode_i.rs2) begin
            op_b_reg = bypass_i.data;
        end
    end

    assign op_b = decode_i.use_imm ? decode_i.imm : op_b_reg;

    always_comb begin
        case (decode_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // beq or bne on the register operands
    assign taken = decode_i.is_branch && ((op_a == op_b_reg) ^ decode_i.branch_ne);

    assign redirect_o.valid = decode_i.valid && (taken || decode_i.is_jal);
    assign redirect_o.pc    = decode_i.pc + decode_i.imm;

    always_comb begin
        exec_d.valid   = decode_i.valid;
        exec_d.pc      = decode_i.pc;
        exec_d.rd      = decode_i.rd;
        exec_d.reg_we  = decode_i.reg_we;
        exec_d.illegal = decode_i.illegal;
        // link value for jal
        exec_d.result  = decode_i.is_jal ? decode_i.pc + 32'd4 : alu_res;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exec_q <= '0;
        end else begin
            exec_q <= exec_d;
        end
    end

    assign exec_o = exec_q;

    // decode must squash the wrong-path slot right after a redirect
    a_redirect_src: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_o.valid |->
            (decode_i.valid && (decode_i.is_branch || decode_i.is_jal)) ##1 !decode_i.valid);

endmodule

//--- source/writeback.sv
module writeback (
    input  core_pkg::exec_entry_t exec_i,
    output logic                  rf_we_o,
    output core_pkg::reg_addr_t   rf_waddr_o,
    output core_pkg::word_t       rf_wdata_o,
    output core_pkg::bypass_t     bypass_o,
    output core_pkg::commit_t     commit_o
);

    logic write_en;

    // one rule feeds regfile, bypass and commit
    assign write_en = exec_i.valid && exec_i.reg_we && !exec_i.illegal &&
                      (exec_i.rd != '0);

    assign rf_we_o    = write_en;
    assign rf_waddr_o = exec_i.rd;
    assign rf_wdata_o = exec_i.result;

    assign bypass_o.valid = write_en;
    assign bypass_o.rd    = exec_i.rd;
    assign bypass_o.data  = exec_i.result;

    // retire strobe covers illegal words too
    assign commit_o.valid   = exec_i.valid;
    assign commit_o.pc      = exec_i.pc;
    assign commit_o.rd      = exec_i.rd;
    assign commit_o.reg_we  = write_en;
    assign commit_o.data    = exec_i.result;
    assign commit_o.illegal = exec_i.illegal;

endmodule

//--- source/datapath.sv
module datapath #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  core_pkg::word_t   imem_rdata_i,
    input  logic              imem_valid_i,
    output core_pkg::word_t   imem_addr_o,
    output core_pkg::commit_t commit_o
);
    import core_pkg::*;

    fetch_entry_t  fetch_entry;
    decode_entry_t decode_entry;
    exec_entry_t   exec_entry;
    redirect_t     redirect;
    bypass_t       bypass;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    word_t         rs1_data;
    word_t         rs2_data;
    logic          rf_we;
    reg_addr_t     rf_waddr;
    word_t         rf_wdata;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .imem_rdata_i(imem_rdata_i),
        .imem_valid_i(imem_valid_i),
        .redirect_i  (redirect),
        .imem_addr_o (imem_addr_o),
        .fetch_o     (fetch_entry)
    );

    // decode squashes its slot on the same redirect
    decoder decoder_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .fetch_i   (fetch_entry),
        .flush_i   (redirect.valid),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .decode_o  (decode_entry)
    );

    regfile regfile_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    alu_exec alu_exec_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .decode_i  (decode_entry),
        .bypass_i  (bypass),
        .redirect_o(redirect),
        .exec_o    (exec_entry)
    );

    writeback writeback_i (
        .exec_i    (exec_entry),
        .rf_we_o   (rf_we),
        .rf_waddr_o(rf_waddr),
        .rf_wdata_o(rf_wdata),
        .bypass_o  (bypass),
        .commit_o  (commit_o)
    );

endmodule

//--- dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int mismatch_count = 0;
int other_count    = 0;

task automatic check_pc(input word_t got, input word_t exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatch_count++;
    end
endtask

// data is only defined for commits that write a register
task automatic check_commit(input commit_t got, input commit_t exp);
    check_pc(got.pc, exp.pc, "commit_o.pc");
    if (got.rd !== exp.rd) begin
        $display("mismatch at %0t: commit_o.rd got %0d expected %0d", $time, got.rd, exp.rd);
        mismatch_count++;
    end
    if (got.reg_we !== exp.reg_we) begin
        $display("mismatch at %0t: commit_o.reg_we got %b expected %b",
                 $time, got.reg_we, exp.reg_we);
        mismatch_count++;
    end
    if (got.illegal !== exp.illegal) begin
        $display("mismatch at %0t: commit_o.illegal got %b expected %b",
                 $time, got.illegal, exp.illegal);
        mismatch_count++;
    end
    if (exp.reg_we && got.data !== exp.data) begin
        $display("mismatch at %0t: commit_o.data got %h expected %h",
                 $time, got.data, exp.data);
        mismatch_count++;
    end
endtask

`endif

//--- dv/tb_datapath.sv
module tb_datapath;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    `include "tb_checks.svh"

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam word_t END_WORD = 32'h0000_006f;
    localparam int LEN_DEP    = 11;
    localparam int LEN_SHIFT  = 12;
    localparam int LEN_BRANCH = 14;
    localparam int LEN_ILL    = 4;
    localparam int CYCLE_LIMIT =
        3 * 4 * (2 * LEN_DEP + LEN_SHIFT + LEN_BRANCH + LEN_ILL);

    logic    clk_i;
    logic    rstn_i;
    logic    imem_valid_i;
    word_t   imem_rdata_i;
    word_t   imem_addr_o;
    commit_t commit_o;

    word_t   prog [64];
    int      prog_len;
    word_t   imem_idx;
    logic    drop_mode;
    logic [31:0] rng;
    int      cycle_count;
    commit_t exp_q [$];
    commit_t got_q [$];

    datapath #(
        .RESET_PC(RESET_PC)
    ) datapath_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .imem_rdata_i(imem_rdata_i),
        .imem_valid_i(imem_valid_i),
        .imem_addr_o (imem_addr_o),
        .commit_o    (commit_o)
    );

    // words past the program hold an address-based pattern
    function automatic word_t fill_word(input word_t addr);
        return {addr[24:0] ^ {18'b0, addr[31:25]}, 7'b0000000};
    endfunction

    assign imem_idx     = (imem_addr_o - RESET_PC) >> 2;
    assign imem_rdata_i = (imem_idx < word_t'(prog_len)) ? prog[imem_idx[5:0]] :
                          fill_word(imem_addr_o);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(posedge clk_i) begin
        rng <= lcg_next(rng);
        if (drop_mode) begin
            imem_valid_i <= (rng[17:16] != 2'b00);
        end else begin
            imem_valid_i <= 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (rstn_i && commit_o.valid) begin
            got_q.push_back(commit_o);
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                    input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(input int imm, input int rd);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic word_t enc_b(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // instruction-set model that yields one commit per retired word
    task automatic run_model();
        word_t   regs [32];
        word_t   pc;
        word_t   off;
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   res;
        word_t   next_pc;
        logic    legal;
        logic    wr;
        logic [2:0] f3;
        logic [6:0] f7;
        commit_t c;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc = RESET_PC;
        for (int step = 0; step < 200; step++) begin
            off = (pc - RESET_PC) >> 2;
            ins = (off < word_t'(prog_len)) ? prog[off[5:0]] : fill_word(pc);
            f3 = ins[14:12];
            f7 = ins[31:25];
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            legal = 1'b1;
            wr = 1'b1;
            res = '0;
            next_pc = pc + 32'd4;
            case (ins[6:0])
                OPC_OP, OPC_OP_IMM: begin
                    if (ins[6:0] == OPC_OP_IMM) begin
                        b = imm;
                        legal = (f3 != 3'd1) && (f3 != 3'd5) && (f3 != 3'd3);
                    end else begin
                        legal = (f3 != 3'd3) && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd0));
                    end
                    case (f3)
                        3'd0: res = (ins[6:0] == OPC_OP && f7[5]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = {31'b0, $signed(a) < $signed(b)};
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[4:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                OPC_LUI: res = {ins[31:12], 12'b0};
                OPC_BRANCH: begin
                    wr = 1'b0;
                    legal = (f3[2:1] == 2'b00);
                    if (legal && ((a == b) ^ f3[0])) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    res = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: legal = 1'b0;
            endcase
            c = '0;
            c.valid = 1'b1;
            c.pc = pc;
            c.rd = ins[11:7];
            c.illegal = !legal;
            c.reg_we = legal && wr && (ins[11:7] != 5'd0);
            c.data = res;
            exp_q.push_back(c);
            if (c.reg_we) begin
                regs[c.rd] = res;
            end
            if (ins == END_WORD) begin
                break;
            end
            pc = next_pc;
        end
    endtask

    // also covers the post-reset fetch address and the empty pipe
    task automatic apply_reset();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        got_q.delete();
        @(negedge clk_i);
        check_pc(imem_addr_o, RESET_PC, "imem_addr_o");
        repeat (2) @(negedge clk_i);
        if (got_q.size() != 0) begin
            $display("commit seen at %0t before the first instruction could retire", $time);
            other_count++;
        end
    endtask

    task automatic run_program(input string name, input logic drop);
        int waited;
        drop_mode = drop;
        run_model();
        apply_reset();
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 12 * exp_q.size()) begin
            @(posedge clk_i);
            waited++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("%s: missing commits, expected %0d but saw %0d",
                     name, exp_q.size(), got_q.size());
            other_count++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_commit(got_q[i], exp_q[i]);
        end
    endtask

    task automatic load_dependent();
        prog_len = 0;
        emit(enc_i(5, 0, 0, 1));
        emit(enc_r(0, 1, 1, 0, 2));
        emit(enc_r(32, 1, 2, 0, 3));
        emit(enc_i(-7, 3, 0, 4));
        emit(enc_r(0, 2, 4, 4, 5));
        emit(enc_r(0, 1, 5, 6, 6));
        emit(enc_r(0, 2, 6, 7, 7));
        emit(enc_i(255, 7, 7, 8));
        emit(enc_i(256, 8, 6, 9));
        emit(enc_i(-1, 9, 4, 10));
        emit(END_WORD);
    endtask

    task automatic test_dependent_ops();
        load_dependent();
        run_program("dependent ops", 1'b0);
    endtask

    task automatic test_shift_compare();
        prog_len = 0;
        emit(enc_u(32'h80000, 1));
        emit(enc_i(-3, 0, 0, 2));
        emit(enc_i(4, 0, 0, 4));
        emit(enc_r(0, 4, 2, 1, 3));
        emit(enc_r(0, 4, 2, 5, 5));
        emit(enc_r(0, 4, 2, 2, 6));
        emit(enc_r(0, 2, 4, 2, 7));
        emit(enc_i(-2, 2, 2, 8));
        emit(enc_i(0, 1, 2, 9));
        emit(enc_u(32'h12345, 10));
        emit(enc_r(0, 4, 1, 5, 11));
        emit(END_WORD);
        run_program("shift and compare", 1'b0);
    endtask

    task automatic test_branch_jump();
        prog_len = 0;
        emit(enc_i(3, 0, 0, 1));
        emit(enc_i(3, 0, 0, 2));
        emit(enc_b(8, 2, 1, 0));
        emit(enc_i(1, 0, 0, 3));
        emit(enc_b(8, 2, 1, 1));
        emit(enc_i(2, 0, 0, 4));
        emit(enc_j(8, 5));
        emit(enc_i(9, 0, 0, 6));
        // x0 must stay zero
        emit(enc_i(7, 0, 0, 0));
        emit(enc_r(0, 5, 0, 0, 7));
        emit(enc_b(8, 0, 1, 1));
        emit(enc_i(1, 0, 0, 8));
        emit(enc_b(8, 0, 1, 0));
        emit(END_WORD);
        run_program("branch and jump", 1'b0);
    endtask

    task automatic test_fetch_bubbles();
        load_dependent();
        run_program("fetch bubbles", 1'b1);
    endtask

    task automatic test_illegal();
        prog_len = 0;
        emit(enc_i(42, 0, 0, 3));
        emit(32'h0000_01ff);
        emit(enc_r(0, 0, 3, 0, 4));
        emit(END_WORD);
        run_program("illegal opcode", 1'b0);
    endtask

    initial begin
        rstn_i       = 1'b0;
        imem_valid_i = 1'b0;
        drop_mode    = 1'b0;
        rng          = 32'd36;
        cycle_count  = 0;
        prog_len     = 0;
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        test_dependent_ops();
        test_shift_compare();
        test_branch_jump();
        test_fetch_bubbles();
        test_illegal();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
source/core_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/regfile.sv
source/alu_exec.sv
source/writeback.sv
source/datapath.sv
dv/tb_datapath.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, then scan the log for failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_datapath -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || echo "simulation ok"
